// File: design/alu_pkg.sv
package alu_pkg;

        localparam int xlen = 64;

        // numbering follows the original ALU select codes.
        typedef enum logic [4:0] {
                op_add, op_sub, op_mul,
                op_div, op_divu, op_rem, op_remu,
                op_and, op_or, op_xor,
                op_sgeu, op_sltu, op_seq, op_sne, op_sge, op_slt,
                op_sll, op_sra, op_srl,
                op_addw, op_subw, op_sllw, op_sraw, op_srlw,
                op_mulw, op_divw, op_divuw, op_remw, op_remuw
        } alu_op_t;

        localparam logic [6:0] opc_op        = 7'b0110011;
        localparam logic [6:0] opc_op_imm    = 7'b0010011;
        localparam logic [6:0] opc_op_32     = 7'b0111011;
        localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
        localparam logic [6:0] opc_branch    = 7'b1100011;

        localparam logic [6:0] funct7_base   = 7'b0000000;
        localparam logic [6:0] funct7_alt    = 7'b0100000;   // sub and sra.
        localparam logic [6:0] funct7_muldiv = 7'b0000001;

        // same 32-bit word, register and immediate layouts.
        typedef union packed {
                struct packed {
                        logic [6:0] funct7;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } r;
                struct packed {
                        logic [11:0] imm;
                        logic [4:0]  rs1;
                        logic [2:0]  funct3;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } i;
        } instr_t;

endpackage

// File: design/instr_decode.sv
module instr_decode (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      instr_valid,
        input  alu_pkg::instr_t           instr,
        input  logic [alu_pkg::xlen-1:0]  rs1_data,
        input  logic [alu_pkg::xlen-1:0]  rs2_data,
        output logic                      dec_valid,
        output logic                      dec_branch,
        output logic                      dec_illegal,
        output logic [4:0]                dec_rd,
        output alu_pkg::alu_op_t          dec_op,
        output logic [alu_pkg::xlen-1:0]  dec_a,
        output logic [alu_pkg::xlen-1:0]  dec_b
);
        import alu_pkg::*;

        alu_op_t          op_c;
        logic [xlen-1:0]  b_c;
        logic             branch_c;
        logic             illegal_c;
        logic [xlen-1:0]  imm_sext;
        logic [xlen-1:0]  shamt6;
        logic [xlen-1:0]  shamt5;
        logic [5:0]       funct6;       // upper imm bits of the 64-bit shifts.

        assign imm_sext = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
        assign shamt6   = {{(xlen-6){1'b0}}, instr.i.imm[5:0]};
        assign shamt5   = {{(xlen-5){1'b0}}, instr.i.imm[4:0]};
        assign funct6   = instr.i.imm[11:6];

        always_comb begin
                op_c      = op_add;
                b_c       = rs2_data;
                branch_c  = 1'b0;
                illegal_c = 1'b0;
                case (instr.r.opcode)
                        opc_op: begin
                                case ({instr.r.funct7, instr.r.funct3})
                                        {funct7_base, 3'd0}:   op_c = op_add;
                                        {funct7_base, 3'd1}:   op_c = op_sll;
                                        {funct7_base, 3'd2}:   op_c = op_slt;
                                        {funct7_base, 3'd3}:   op_c = op_sltu;
                                        {funct7_base, 3'd4}:   op_c = op_xor;
                                        {funct7_base, 3'd5}:   op_c = op_srl;
                                        {funct7_base, 3'd6}:   op_c = op_or;
                                        {funct7_base, 3'd7}:   op_c = op_and;
                                        {funct7_alt, 3'd0}:    op_c = op_sub;
                                        {funct7_alt, 3'd5}:    op_c = op_sra;
                                        {funct7_muldiv, 3'd0}: op_c = op_mul;
                                        {funct7_muldiv, 3'd4}: op_c = op_div;
                                        {funct7_muldiv, 3'd5}: op_c = op_divu;
                                        {funct7_muldiv, 3'd6}: op_c = op_rem;
                                        {funct7_muldiv, 3'd7}: op_c = op_remu;
                                        default:               illegal_c = 1'b1;   // mulh too.
                                endcase
                        end
                        opc_op_imm: begin
                                b_c = imm_sext;
                                case (instr.i.funct3)
                                        3'd0: op_c = op_add;
                                        3'd2: op_c = op_slt;
                                        3'd3: op_c = op_sltu;
                                        3'd4: op_c = op_xor;
                                        3'd6: op_c = op_or;
                                        3'd7: op_c = op_and;
                                        3'd1: begin
                                                op_c      = op_sll;
                                                b_c       = shamt6;
                                                illegal_c = funct6 != 6'd0;
                                        end
                                        default: begin
                                                // srai sets funct6[4].
                                                op_c      = funct6[4] ? op_sra : op_srl;
                                                b_c       = shamt6;
                                                illegal_c = (funct6 & 6'b101111) != 6'd0;
                                        end
                                endcase
                        end
                        opc_op_32: begin
                                case ({instr.r.funct7, instr.r.funct3})
                                        {funct7_base, 3'd0}:   op_c = op_addw;
                                        {funct7_base, 3'd1}:   op_c = op_sllw;
                                        {funct7_base, 3'd5}:   op_c = op_srlw;
                                        {funct7_alt, 3'd0}:    op_c = op_subw;
                                        {funct7_alt, 3'd5}:    op_c = op_sraw;
                                        {funct7_muldiv, 3'd0}: op_c = op_mulw;
                                        {funct7_muldiv, 3'd4}: op_c = op_divw;
                                        {funct7_muldiv, 3'd5}: op_c = op_divuw;
                                        {funct7_muldiv, 3'd6}: op_c = op_remw;
                                        {funct7_muldiv, 3'd7}: op_c = op_remuw;
                                        default:               illegal_c = 1'b1;
                                endcase
                        end
                        opc_op_imm_32: begin
                                b_c = imm_sext;
                                case (instr.i.funct3)
                                        3'd0: op_c = op_addw;
                                        3'd1: begin
                                                op_c      = op_sllw;
                                                b_c       = shamt5;
                                                illegal_c = instr.r.funct7 != funct7_base;
                                        end
                                        3'd5: begin
                                                op_c      = (instr.r.funct7 == funct7_alt) ?
                                                            op_sraw : op_srlw;
                                                b_c       = shamt5;
                                                illegal_c = !(instr.r.funct7 inside
                                                              {funct7_base, funct7_alt});
                                        end
                                        default: illegal_c = 1'b1;
                                endcase
                        end
                        opc_branch: begin
                                branch_c = 1'b1;
                                case (instr.r.funct3)
                                        3'd0: op_c = op_seq;
                                        3'd1: op_c = op_sne;
                                        3'd4: op_c = op_slt;
                                        3'd5: op_c = op_sge;
                                        3'd6: op_c = op_sltu;
                                        3'd7: op_c = op_sgeu;
                                        default: illegal_c = 1'b1;
                                endcase
                        end
                        default: illegal_c = 1'b1;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        dec_valid   <= 1'b0;
                        dec_branch  <= 1'b0;
                        dec_illegal <= 1'b0;
                        dec_rd      <= '0;
                        dec_op      <= op_add;
                        dec_a       <= '0;
                        dec_b       <= '0;
                end else begin
                        dec_valid   <= instr_valid;
                        dec_branch  <= branch_c;
                        dec_illegal <= illegal_c;
                        dec_rd      <= instr.r.rd;     // imm bits for a branch.
                        dec_op      <= op_c;
                        dec_a       <= rs1_data;
                        dec_b       <= b_c;
                end
        end

endmodule

// File: design/alu_execute.sv
module alu_execute (
        input  alu_pkg::alu_op_t          op,
        input  logic [alu_pkg::xlen-1:0]  a,
        input  logic [alu_pkg::xlen-1:0]  b,
        output logic [alu_pkg::xlen-1:0]  res
);
        import alu_pkg::*;

        logic signed [xlen-1:0]  a_s;
        logic signed [xlen-1:0]  b_s;
        logic [31:0]             a_w;
        logic [31:0]             b_w;
        logic signed [31:0]      aw_s;
        logic signed [31:0]      bw_s;
        logic [31:0]             wres;
        logic                    ovf;          // most negative over -1.
        logic                    ovf_w;

        assign a_s   = a;
        assign b_s   = b;
        assign a_w   = a[31:0];
        assign b_w   = b[31:0];
        assign aw_s  = a_w;
        assign bw_s  = b_w;
        assign ovf   = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
        assign ovf_w = (a_w == 32'h8000_0000) && (b_w == '1);

        // low word result of the W forms.
        always_comb begin
                case (op)
                        op_addw:  wres = a_w + b_w;
                        op_subw:  wres = a_w - b_w;
                        op_sllw:  wres = a_w << b[4:0];
                        op_sraw:  wres = aw_s >>> b[4:0];
                        op_srlw:  wres = a_w >> b[4:0];
                        op_mulw:  wres = a_w * b_w;
                        op_divw:  wres = (b_w == '0) ? '1 : ovf_w ? a_w : $unsigned(aw_s / bw_s);
                        op_divuw: wres = (b_w == '0) ? '1 : a_w / b_w;
                        op_remw:  wres = (b_w == '0) ? a_w : ovf_w ? '0 : $unsigned(aw_s % bw_s);
                        op_remuw: wres = (b_w == '0) ? a_w : a_w % b_w;
                        default:  wres = '0;
                endcase
        end

        always_comb begin
                res = '0;
                case (op)
                        op_add:  res = a + b;
                        op_sub:  res = a - b;
                        op_mul:  res = a * b;
                        op_div:  res = (b == '0) ? '1 : ovf ? a : $unsigned(a_s / b_s);
                        op_divu: res = (b == '0) ? '1 : a / b;
                        op_rem:  res = (b == '0) ? a : ovf ? '0 : $unsigned(a_s % b_s);
                        op_remu: res = (b == '0) ? a : a % b;
                        op_and:  res = a & b;
                        op_or:   res = a | b;
                        op_xor:  res = a ^ b;
                        op_sgeu: res[0] = a >= b;
                        op_sltu: res[0] = a < b;
                        op_seq:  res[0] = a == b;
                        op_sne:  res[0] = a != b;
                        op_sge:  res[0] = a_s >= b_s;
                        op_slt:  res[0] = a_s < b_s;
                        op_sll:  res = a << b[5:0];
                        op_sra:  res = a_s >>> b[5:0];
                        op_srl:  res = a >> b[5:0];
                        op_addw, op_subw, op_sllw, op_sraw, op_srlw,
                        op_mulw, op_divw, op_divuw, op_remw, op_remuw:
                                res = {{(xlen-32){wres[31]}}, wres};   // sign extend bit 31.
                        default: res = '0;
                endcase
        end

endmodule

// File: design/result_stage.sv
module result_stage (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      dec_valid,
        input  logic                      dec_branch,
        input  logic                      dec_illegal,
        input  logic [4:0]                dec_rd,
        input  logic [alu_pkg::xlen-1:0]  alu_res,
        output logic                      wb_valid,
        output logic [4:0]                wb_rd,
        output logic [alu_pkg::xlen-1:0]  wb_data,
        output logic                      br_valid,
        output logic                      br_taken,
        output logic                      illegal_instr
);
        logic is_illegal;
        logic is_branch;
        logic is_write;

        assign is_illegal = dec_valid && dec_illegal;
        assign is_branch  = dec_valid && !dec_illegal && dec_branch;
        // writes to x0 are dropped.
        assign is_write   = dec_valid && !dec_illegal && !dec_branch && (dec_rd != 5'd0);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wb_valid      <= 1'b0;
                        wb_rd         <= '0;
                        wb_data       <= '0;
                        br_valid      <= 1'b0;
                        br_taken      <= 1'b0;
                        illegal_instr <= 1'b0;
                end else begin
                        wb_valid      <= is_write;
                        wb_rd         <= dec_rd;
                        wb_data       <= alu_res;
                        br_valid      <= is_branch;
                        br_taken      <= is_branch && alu_res[0];   // compare result.
                        illegal_instr <= is_illegal;
                end
        end

endmodule

// File: design/alu_core.sv
module alu_core (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      instr_valid,
        input  alu_pkg::instr_t           instr,
        input  logic [alu_pkg::xlen-1:0]  rs1_data,
        input  logic [alu_pkg::xlen-1:0]  rs2_data,
        output logic                      wb_valid,
        output logic [4:0]                wb_rd,
        output logic [alu_pkg::xlen-1:0]  wb_data,
        output logic                      br_valid,
        output logic                      br_taken,
        output logic                      illegal_instr
);
        import alu_pkg::*;

        logic             dec_valid;
        logic             dec_branch;
        logic             dec_illegal;
        logic [4:0]       dec_rd;
        alu_op_t          dec_op;
        logic [xlen-1:0]  dec_a;
        logic [xlen-1:0]  dec_b;
        logic [xlen-1:0]  alu_res;

        instr_decode u_decode (
                .clk         (clk),
                .rst_n       (rst_n),
                .instr_valid (instr_valid),
                .instr       (instr),
                .rs1_data    (rs1_data),
                .rs2_data    (rs2_data),
                .dec_valid   (dec_valid),
                .dec_branch  (dec_branch),
                .dec_illegal (dec_illegal),
                .dec_rd      (dec_rd),
                .dec_op      (dec_op),
                .dec_a       (dec_a),
                .dec_b       (dec_b)
        );

        // combinational, between the two register stages.
        alu_execute u_execute (
                .op  (dec_op),
                .a   (dec_a),
                .b   (dec_b),
                .res (alu_res)
        );

        result_stage u_result (
                .clk           (clk),
                .rst_n         (rst_n),
                .dec_valid     (dec_valid),
                .dec_branch    (dec_branch),
                .dec_illegal   (dec_illegal),
                .dec_rd        (dec_rd),
                .alu_res       (alu_res),
                .wb_valid      (wb_valid),
                .wb_rd         (wb_rd),
                .wb_data       (wb_data),
                .br_valid      (br_valid),
                .br_taken      (br_taken),
                .illegal_instr (illegal_instr)
        );

endmodule

// File: bench/alu_core_properties.sv
module alu_core_properties (
        input logic             clk,
        input logic             rst_n,
        input logic             instr_valid,
        input alu_pkg::instr_t  instr,
        input logic             wb_valid,
        input logic             br_valid,
        input logic             illegal_instr
);
        logic [2:0]  strobes;
        logic [4:0]  instr_rd;
        int          assert_errors = 0;

        assign strobes  = {wb_valid, br_valid, illegal_instr};
        assign instr_rd = instr.r.rd;

        a_exclusive: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(strobes))
        else begin
                assert_errors++;
                $error("more than one output strobe high");
        end

        a_reset_quiet: assert property (@(posedge clk) !rst_n |=> strobes == 3'b000)
        else begin
                assert_errors++;
                $error("output strobe high during reset");
        end

        // a write to x0 leaves all strobes low.
        a_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                        $past(instr_valid, 2) |->
                        $onehot(strobes) ||
                        ($past(instr_rd, 2) == 5'd0 && strobes == 3'b000))
        else begin
                assert_errors++;
                $error("instruction gave no single result strobe 2 cycles later");
        end

endmodule

bind alu_core alu_core_properties i_props (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .br_valid      (br_valid),
        .illegal_instr (illegal_instr)
);

// File: bench/alu_checker.sv
module alu_checker (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      instr_valid,
        input  alu_pkg::instr_t           instr,
        input  logic [7:0]                exp_kind,
        input  logic [4:0]                exp_rd,
        input  logic [alu_pkg::xlen-1:0]  exp_value,
        input  logic                      wb_valid,
        input  logic [4:0]                wb_rd,
        input  logic [alu_pkg::xlen-1:0]  wb_data,
        input  logic                      br_valid,
        input  logic                      br_taken,
        input  logic                      illegal_instr,
        output int                        pass_count,
        output int                        fail_count,
        output int                        pending
);
        import alu_pkg::*;

        typedef struct packed {
                logic [31:0]      instr;
                logic [7:0]       kind;
                logic [4:0]       rd;
                logic [xlen-1:0]  value;
                int               due;      // cycle the result must show.
                int               num;
        } expect_t;

        expect_t  exp_q [$];
        int       cyc;
        int       num_sent;

        task automatic compare(input expect_t e, input logic [2:0] seen);
                logic [2:0]  want;
                bit          ok;
                instr_t      iw;
                iw = e.instr;
                ok = 1'b1;
                case (e.kind)
                        "w":     want = 3'b100;
                        "b":     want = 3'b010;
                        "i":     want = 3'b001;
                        default: want = 3'b000;
                endcase
                if (want != 3'b000 && seen == 3'b000) begin
                        $display("test %0d failed: no result came out 2 cycles after it was sent",
                                 e.num);
                        ok = 1'b0;
                end else if (seen != want) begin
                        $display("error at %0t: test %0d strobes wb/br/ill %b, expected %b",
                                 $time, e.num, seen, want);
                        ok = 1'b0;
                end else if (e.kind == "w" && (wb_rd != e.rd || wb_data != e.value)) begin
                        $display("error at %0t: test %0d wrote x%0d = 0x%h, expected x%0d = 0x%h",
                                 $time, e.num, wb_rd, wb_data, e.rd, e.value);
                        ok = 1'b0;
                end else if (e.kind == "b" && br_taken != e.value[0]) begin
                        $display("error at %0t: test %0d br_taken %b, expected %b",
                                 $time, e.num, br_taken, e.value[0]);
                        ok = 1'b0;
                end
                if (ok) begin
                        pass_count++;
                        $display("test %0d ok: opcode 0x%h rd field x%0d kind %c",
                                 e.num, iw.r.opcode, iw.r.rd, e.kind);
                end else begin
                        fail_count++;
                end
        endtask

        // outputs read here are the values registered on the previous edge.
        always @(posedge clk) begin : watch
                expect_t     e;
                logic [2:0]  seen;
                if (!rst_n) begin
                        cyc        = 0;
                        num_sent   = 0;
                        pass_count = 0;
                        fail_count = 0;
                        exp_q.delete();
                end else begin
                        cyc  = cyc + 1;
                        seen = {wb_valid, br_valid, illegal_instr};
                        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                                e = exp_q.pop_front();
                                compare(e, seen);
                        end else if (seen != 3'b000) begin
                                $display("an output strobe fired with no instruction due at %0t",
                                         $time);
                                fail_count++;
                        end
                        if (instr_valid) begin
                                num_sent++;
                                e = {instr, exp_kind, exp_rd, exp_value, cyc + 2, num_sent};
                                exp_q.push_back(e);
                        end
                end
                pending = exp_q.size();
        end

endmodule

// File: bench/tb_alu_core.sv
module tb_alu_core;
        import alu_pkg::*;

        logic             clk;
        logic             rst_n;
        logic             instr_valid;
        instr_t           instr;
        logic [xlen-1:0]  rs1_data;
        logic [xlen-1:0]  rs2_data;
        logic             wb_valid;
        logic [4:0]       wb_rd;
        logic [xlen-1:0]  wb_data;
        logic             br_valid;
        logic             br_taken;
        logic             illegal_instr;
        logic [7:0]       exp_kind;
        logic [4:0]       exp_rd;
        logic [xlen-1:0]  exp_value;
        int               pass_count;
        int               fail_count;
        int               pending;

        logic [31:0]      vec_instr [$];
        logic [xlen-1:0]  vec_rs1 [$];
        logic [xlen-1:0]  vec_rs2 [$];
        logic [7:0]       vec_kind [$];
        logic [4:0]       vec_rd [$];
        logic [xlen-1:0]  vec_value [$];
        integer           seed;
        bit               loaded;
        bit               drained;

        alu_core i_dut (
                .clk           (clk),
                .rst_n         (rst_n),
                .instr_valid   (instr_valid),
                .instr         (instr),
                .rs1_data      (rs1_data),
                .rs2_data      (rs2_data),
                .wb_valid      (wb_valid),
                .wb_rd         (wb_rd),
                .wb_data       (wb_data),
                .br_valid      (br_valid),
                .br_taken      (br_taken),
                .illegal_instr (illegal_instr)
        );

        alu_checker i_check (
                .clk           (clk),
                .rst_n         (rst_n),
                .instr_valid   (instr_valid),
                .instr         (instr),
                .exp_kind      (exp_kind),
                .exp_rd        (exp_rd),
                .exp_value     (exp_value),
                .wb_valid      (wb_valid),
                .wb_rd         (wb_rd),
                .wb_data       (wb_data),
                .br_valid      (br_valid),
                .br_taken      (br_taken),
                .illegal_instr (illegal_instr),
                .pass_count    (pass_count),
                .fail_count    (fail_count),
                .pending       (pending)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        task automatic load_vectors(output bit ok);
                int               fd;
                int               n;
                int               rd;
                string            line;
                logic [31:0]      iw;
                logic [xlen-1:0]  a;
                logic [xlen-1:0]  b;
                logic [xlen-1:0]  v;
                logic [7:0]       k;
                ok = 1'b0;
                fd = $fopen("bench/alu_input.txt", "r");
                if (fd == 0)
                        return;
                while ($fgets(line, fd) != 0) begin
                        if (line.len() < 2 || line[0] == "#")
                                continue;    // column notes or blank.
                        n = $sscanf(line, "%h %h %h %c %d %h", iw, a, b, k, rd, v);
                        if (n != 6) begin
                                $display("malformed line in the input file: %s", line);
                                $fclose(fd);
                                return;
                        end
                        vec_instr.push_back(iw);
                        vec_rs1.push_back(a);
                        vec_rs2.push_back(b);
                        vec_kind.push_back(k);
                        vec_rd.push_back(rd[4:0]);
                        vec_value.push_back(v);
                end
                $fclose(fd);
                ok = vec_instr.size() != 0;
        endtask

        task automatic drive_vector(input int idx);
                @(negedge clk);
                instr_valid = 1'b1;
                instr       = vec_instr[idx];
                rs1_data    = vec_rs1[idx];
                rs2_data    = vec_rs2[idx];
                exp_kind    = vec_kind[idx];
                exp_rd      = vec_rd[idx];
                exp_value   = vec_value[idx];
        endtask

        task automatic drive_idle(input int cycles);
                repeat (cycles) begin
                        @(negedge clk);
                        instr_valid = 1'b0;
                end
        endtask

        task automatic wait_drain(output bit done);
                int cycles;
                cycles = 0;
                while (pending != 0 && cycles < 20) begin
                        @(negedge clk);
                        cycles++;
                end
                done = pending == 0;
        endtask

        initial begin
                int gap;
                seed        = 80;
                rst_n       = 1'b0;
                instr_valid = 1'b0;
                instr       = '0;
                rs1_data    = '0;
                rs2_data    = '0;
                exp_kind    = '0;
                exp_rd      = '0;
                exp_value   = '0;
                drained     = 1'b0;
                load_vectors(loaded);
                if (!loaded)
                        $display("could not read any vectors from bench/alu_input.txt");
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                if (loaded) begin
                        foreach (vec_instr[i]) begin
                                drive_vector(i);
                                gap = 1 + int'({$random(seed)} % 3);
                                drive_idle(gap);
                        end
                        // back-to-back burst of the same vectors.
                        foreach (vec_instr[i])
                                drive_vector(i);
                        drive_idle(1);
                        wait_drain(drained);
                        drive_idle(3);
                        if (!drained)
                                $display("timed out with %0d results still outstanding", pending);
                end
                if (i_dut.i_props.assert_errors != 0)
                        $display("%0d assertion failures seen", i_dut.i_props.assert_errors);
                $display("tests passed %0d, failed %0d", pass_count, fail_count);
                if (loaded && drained && fail_count == 0 &&
                    pass_count == 2 * vec_instr.size() &&
                    i_dut.i_props.assert_errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

// File: bench/alu_input.txt
# instr rs1 rs2 kind rd value (hex except rd, which is decimal)
# kind: w write to rd, b branch with taken in value bit 0, i illegal, n no output
002082B3 7FFFFFFFFFFFFFFF 0000000000000001 w 5 8000000000000000
40208333 0000000000000005 0000000000000007 w 6 FFFFFFFFFFFFFFFE
FFD08393 000000000000000A 0000000000000000 w 7 0000000000000007
4040D413 F000000000000000 0000000000000000 w 8 FF00000000000000
0040D493 F000000000000000 0000000000000000 w 9 0F00000000000000
0020C533 FF00FF00FF00FF00 0FF00FF00FF00FF0 w 10 F0F0F0F0F0F0F0F0
022085B3 0000000100000000 0000000100000003 w 11 0000000300000000
0220C633 0000000000000123 0000000000000000 w 12 FFFFFFFFFFFFFFFF
0220E6B3 0000000000000123 0000000000000000 w 13 0000000000000123
0220C733 8000000000000000 FFFFFFFFFFFFFFFF w 14 8000000000000000
0220E7B3 FFFFFFFFFFFFFFF9 0000000000000002 w 15 FFFFFFFFFFFFFFFF
0020883B 123456787FFFFFFF 0000000000000001 w 16 FFFFFFFF80000000
4040D89B 0000000080000000 0000000000000000 w 17 FFFFFFFFF8000000
0020993B 0000000040000000 0000000000000021 w 18 FFFFFFFF80000000
00208063 0000000000000005 0000000000000005 b 0 0000000000000001
00209063 0000000000000005 0000000000000005 b 0 0000000000000000
0020C063 FFFFFFFFFFFFFFFF 0000000000000001 b 0 0000000000000001
0020D063 FFFFFFFFFFFFFFFF 0000000000000001 b 0 0000000000000000
0020E063 FFFFFFFFFFFFFFFF 0000000000000001 b 0 0000000000000000
0020F063 FFFFFFFFFFFFFFFF 0000000000000001 b 0 0000000000000001
000001FF 0000000000000001 0000000000000002 i 0 0000000000000000
0200921B 0000000000000001 0000000000000000 i 0 0000000000000000
00208033 0000000000000001 0000000000000002 n 0 0000000000000000

// File: alu_core.f
design/alu_pkg.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_stage.sv
design/alu_core.sv
bench/alu_core_properties.sv
bench/alu_checker.sv
bench/tb_alu_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the alu_core testbench, then judge the log.
rm -f sim.log
verilator --binary --assert --top-module tb_alu_core -f alu_core.f -o sim_alu_core \
        && ./obj_dir/sim_alu_core +verilator+error+limit+1000 > sim.log 2>&1 \
        || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q "^sim passed$" sim.log 2>/dev/null && echo "result: pass" && exit 0
echo "result: fail"
exit 1
